/* hw/video_pkg.sv */
package video_pkg;

    // position of the current cycle within a raster line, counted from 1
    typedef logic [6:0] cycle_t;

    // raster line number within one frame
    typedef logic [8:0] raster_t;

    // hi-res video matrix counter, 2000 of its 2048 cells are on screen
    typedef logic [10:0] vc_t;

    // row within the current character cell
    typedef logic [2:0] rc_t;

    // fast counter that walks a 16k bitmap one byte per half-cycle
    typedef logic [13:0] fvc_t;

    // address presented to video memory
    typedef logic [15:0] addr_t;

    // tick position within a phi half-phase
    typedef logic [3:0] phase_t;

    // vertical scroll value as it sits in the control register
    typedef logic [2:0] scroll_t;

    // first and last raster lines on which a badline may occur
    localparam raster_t first_dma_line = 9'd48;
    localparam raster_t last_dma_line = 9'd247;

    // the 80x25 text screen geometry
    localparam vc_t row_cells = 11'd80;
    localparam vc_t text_rows = 11'd25;

    // values of the bitmap mode bit
    localparam logic mode_text = 1'b0;
    localparam logic mode_bitmap = 1'b1;

endpackage

/* hw/raster_timing_if.sv */
`timescale 1ns/100ps

// phi clock, phase strobes and raster position shared by the timing blocks
interface raster_timing_if
    import video_pkg::*;
();

    logic clk_phi;
    // bit k pulses for one dot4x tick when the half-phase count is k
    logic [15:0] phase_start;
    cycle_t cycle_num;
    raster_t raster_line;

    modport phi_src (output clk_phi, output phase_start);

    modport line_src (input clk_phi, input phase_start, output cycle_num, output raster_line);

    modport sink (input clk_phi, input phase_start, input cycle_num, input raster_line);

endinterface

/* hw/phi_phase_gen.sv */
`timescale 1ns/100ps

// derives the phi clock and the sixteen phase strobes from the dot4x clock
module phi_phase_gen
    import video_pkg::*;
(
    input logic clk_dot4x,
    input logic rst,
    raster_timing_if.phi_src timing
);

    phase_t phase_cnt;
    logic phi_q;
    // the strobe pattern one tick on, one position further round the ring
    logic [15:0] strobe_next;

    // one half-phase is sixteen ticks, phi flips when the count rolls over
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase_cnt <= '0;
            phi_q <= 1'b0;
        end else begin
            phase_cnt <= phase_cnt + 1'b1;
            if (phase_cnt == 4'd15) begin
                phi_q <= ~phi_q;
            end
        end
    end

    assign timing.clk_phi = phi_q;

    // decode the count into strobes, exactly one is high on every tick
    assign timing.phase_start = 16'd1 << phase_cnt;

    assign strobe_next = {timing.phase_start[14:0], timing.phase_start[15]};

    // the count steps by one every tick, so no strobe is skipped or repeated
    a_phase_step: assert property (@(posedge clk_dot4x) disable iff (rst)
        $onehot(timing.phase_start) |=> timing.phase_start == $past(strobe_next));

    // phi must only change right after the last strobe of a half-phase
    a_phi_edge: assert property (@(posedge clk_dot4x) disable iff (rst)
        $changed(timing.clk_phi) |-> $past(timing.phase_start[15]));

endmodule

/* hw/raster_counter.sv */
`timescale 1ns/100ps

// counts phi cycles within a raster line and lines within a frame
module raster_counter
    import video_pkg::*;
#(
    parameter int cycles_per_line = 63,
    parameter int lines_per_frame = 312
) (
    input logic clk_dot4x,
    input logic rst,
    raster_timing_if.line_src timing
);

    cycle_t cycle_q;
    raster_t line_q;

    // the cycle number moves at the start of the low phase, so it is
    // settled by the time the consumers sample it on strobe 1
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            cycle_q <= cycle_t'(1);
            line_q <= '0;
        end else if (timing.phase_start[0] && !timing.clk_phi) begin
            if (cycle_q == cycle_t'(cycles_per_line)) begin
                cycle_q <= cycle_t'(1);
                // last line of the frame wraps back to line 0
                if (line_q == raster_t'(lines_per_frame - 1)) begin
                    line_q <= '0;
                end else begin
                    line_q <= line_q + 1'b1;
                end
            end else begin
                cycle_q <= cycle_q + 1'b1;
            end
        end
    end

    assign timing.cycle_num = cycle_q;
    assign timing.raster_line = line_q;

    // cycle numbers live in 1..cycles_per_line, zero is never valid
    a_cycle_range: assert property (@(posedge clk_dot4x) disable iff (rst)
        timing.cycle_num != '0 && timing.cycle_num <= cycle_t'(cycles_per_line));

    // a new line starts only when the cycle count wraps to 1
    a_line_step: assert property (@(posedge clk_dot4x) disable iff (rst)
        $changed(timing.raster_line) |-> timing.cycle_num == cycle_t'(1));

endmodule

/* hw/badline_detect.sv */
`timescale 1ns/100ps

// flags the raster lines on which the matrix counters resynchronise
module badline_detect
    import video_pkg::*;
(
    input logic clk_dot4x,
    input logic rst,
    raster_timing_if.sink timing,
    input scroll_t yscroll,
    input logic den,
    output logic badline
);

    // display enable as it stood at the top of the display window
    logic den_frame;
    logic line_start;
    logic den_now;
    logic in_window;

    // first valid sample of cycle 1, which is in the low phase
    assign line_start = timing.phase_start[1] && !timing.clk_phi &&
                        timing.cycle_num == cycle_t'(1);

    // on line 48 itself the live bit counts, the latch is written in the same tick
    assign den_now = (timing.raster_line == first_dma_line) ? den : den_frame;

    assign in_window = timing.raster_line >= first_dma_line &&
                       timing.raster_line <= last_dma_line;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            den_frame <= 1'b0;
            badline <= 1'b0;
        end else if (line_start) begin
            if (timing.raster_line == '0) begin
                den_frame <= 1'b0;
            end else if (timing.raster_line == first_dma_line) begin
                den_frame <= den;
            end
            // the flag holds for the whole line once decided
            badline <= in_window && timing.raster_line[2:0] == yscroll && den_now;
        end
    end

    // once settled for the line, a badline never lies outside the window
    a_badline_window: assert property (@(posedge clk_dot4x) disable iff (rst)
        timing.phase_start[2] && badline |-> in_window);

endmodule

/* hw/hires_matrix.sv */
`timescale 1ns/100ps

// hi-res 80x25 matrix counters
// badlines here steal no CPU cycles, they only mark the lines where the
// yscroll match restarts the vc increments
module hires_matrix
    import video_pkg::*;
(
    input logic clk_dot4x,
    input logic rst,
    raster_timing_if.sink timing,
    input logic badline,
    output vc_t hires_vc,
    output rc_t hires_rc,
    // fast counter for the 16k bitmap mode
    output fvc_t hires_fvc
);

    vc_t vc_base;
    logic idle;
    // one bit per line, set when that line was a badline
    logic [7:0] badline_hist;
    logic idle_at_row_end;
    logic sample;
    logic in_fetch;

    // cycle_num is only settled on strobe 1, in either phase
    assign sample = timing.phase_start[1];

    // 40 cycles with a step on both phases gives 80 cells per line
    assign in_fetch = timing.cycle_num > cycle_t'(14) && timing.cycle_num < cycle_t'(55);

    // at cycle 57 a finished character row forces idle before the
    // badline check below gets its say
    assign idle_at_row_end = (hires_rc == 3'd7) ? 1'b1 : idle;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            vc_base <= '0;
            hires_vc <= '0;
            hires_rc <= 3'd7;
            hires_fvc <= '0;
            badline_hist <= '0;
            idle <= 1'b1;
        end else begin
            if (sample) begin
                // start of frame, high phase of line 0 cycle 1
                if (timing.clk_phi && timing.cycle_num == cycle_t'(1) &&
                    timing.raster_line == '0) begin
                    vc_base <= '0;
                    hires_vc <= '0;
                    hires_fvc <= '0;
                end

                // vc only moves on active rows and so gains 80 per character row,
                // fvc gains 80 on every line while a recent badline is on record
                if (in_fetch) begin
                    if (!idle) begin
                        hires_vc <= hires_vc + 1'b1;
                    end
                    if (badline_hist != '0) begin
                        hires_fvc <= hires_fvc + 1'b1;
                    end
                end

                // reload the row start and record this line in the history
                if (timing.clk_phi && timing.cycle_num == cycle_t'(13)) begin
                    hires_vc <= vc_base;
                    if (badline) begin
                        hires_rc <= '0;
                    end
                    badline_hist <= {badline_hist[6:0], badline};
                end

                // next row at the usual point, high phase only
                if (timing.clk_phi && timing.cycle_num == cycle_t'(57)) begin
                    if (hires_rc == 3'd7) begin
                        vc_base <= hires_vc;
                    end
                    if (!idle_at_row_end || badline) begin
                        hires_rc <= hires_rc + 1'b1;
                        idle <= 1'b0;
                    end else begin
                        idle <= idle_at_row_end;
                    end
                end
            end

            // a badline wakes the counters late in the high phase
            if (timing.clk_phi && timing.phase_start[14] && badline) begin
                idle <= 1'b0;
            end
        end
    end

    // the row base never runs past the last text cell, even when badlines keep coming
    a_vc_limit: assert property (@(posedge clk_dot4x) disable iff (rst)
        hires_vc <= vc_t'(row_cells * text_rows));

endmodule

/* hw/hires_fetch_addr.sv */
`timescale 1ns/100ps

// builds the video memory fetch address from the active counter
module hires_fetch_addr
    import video_pkg::*;
(
    input logic clk_dot4x,
    input logic rst,
    input logic bitmap_mode,
    input logic [4:0] matrix_base,
    input logic [1:0] bitmap_base,
    input vc_t hires_vc,
    input fvc_t hires_fvc,
    output addr_t fetch_addr
);

    addr_t addr_next;

    // the base selects a 2k screen in text mode or a 16k bank in bitmap mode
    always_comb begin
        case (bitmap_mode)
            mode_text: addr_next = {matrix_base, hires_vc};
            mode_bitmap: addr_next = {bitmap_base, hires_fvc};
            default: addr_next = {matrix_base, hires_vc};
        endcase
    end

    // registered, so the address trails a counter change by one tick
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            fetch_addr <= '0;
        end else begin
            fetch_addr <= addr_next;
        end
    end

endmodule

/* hw/hires_video_timing.sv */
`timescale 1ns/100ps

// hi-res text and bitmap timing core
module hires_video_timing
    import video_pkg::*;
#(
    parameter int cycles_per_line = 63,
    parameter int lines_per_frame = 312
) (
    input logic clk_dot4x,
    input logic rst,
    input scroll_t yscroll,
    input logic den,
    input logic bitmap_mode,
    input logic [4:0] matrix_base,
    input logic [1:0] bitmap_base,
    output logic clk_phi,
    output cycle_t cycle_num,
    output raster_t raster_line,
    output logic badline,
    output vc_t hires_vc,
    output rc_t hires_rc,
    output fvc_t hires_fvc,
    output addr_t fetch_addr
);

    raster_timing_if timing ();

    phi_phase_gen phi_phase_gen_inst (.clk_dot4x, .rst, .timing(timing.phi_src));

    raster_counter #(
        .cycles_per_line(cycles_per_line),
        .lines_per_frame(lines_per_frame)
    ) raster_counter_inst (.clk_dot4x, .rst, .timing(timing.line_src));

    badline_detect badline_detect_inst (
        .clk_dot4x, .rst, .timing(timing.sink), .yscroll, .den, .badline
    );

    hires_matrix hires_matrix_inst (
        .clk_dot4x, .rst, .timing(timing.sink), .badline, .hires_vc, .hires_rc, .hires_fvc
    );

    hires_fetch_addr hires_fetch_addr_inst (
        .clk_dot4x, .rst, .bitmap_mode, .matrix_base, .bitmap_base,
        .hires_vc, .hires_fvc, .fetch_addr
    );

    // raster position brought out for the rest of the chip
    assign clk_phi = timing.clk_phi;
    assign cycle_num = timing.cycle_num;
    assign raster_line = timing.raster_line;

endmodule

/* verification/tb_hires_video_timing.sv */
`timescale 1ns/100ps

// directed testbench for the hi-res video timing core
module tb_hires_video_timing
    import video_pkg::*;
();

    localparam int cycles_per_line = 63;
    localparam int lines_per_frame = 312;
    localparam int clk_period_ns = 40;
    // eight yscroll frames and one frame with the display disabled
    localparam int test_frames = 9;
    // one phi cycle is 32 dot4x ticks, one spare frame is added on top
    localparam longint watchdog_ns = longint'(test_frames + 1) * lines_per_frame *
                                     cycles_per_line * 32 * clk_period_ns;

    logic clk_dot4x;
    logic rst;
    scroll_t yscroll;
    logic den;
    logic bitmap_mode;
    logic [4:0] matrix_base;
    logic [1:0] bitmap_base;
    logic clk_phi;
    cycle_t cycle_num;
    raster_t raster_line;
    logic badline;
    vc_t hires_vc;
    rc_t hires_rc;
    fvc_t hires_fvc;
    addr_t fetch_addr;

    // reference model of the raster position and the per-line counter rules
    cycle_t exp_cycle;
    raster_t exp_line;
    logic den_latch;
    logic exp_badline;
    logic [7:0] bl_hist;
    int rows_seen;
    int lines_since_bl;
    int fvc_lines;

    hires_video_timing #(
        .cycles_per_line(cycles_per_line),
        .lines_per_frame(lines_per_frame)
    ) hires_video_timing_inst (.*);

    initial begin
        clk_dot4x = 1'b0;
        forever #(clk_period_ns / 2) clk_dot4x = ~clk_dot4x;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_vc(input vc_t got, input vc_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] hires_vc got %h expected %h", got, exp));
        end
    endtask

    task automatic check_rc(input rc_t got, input rc_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] hires_rc got %h expected %h", got, exp));
        end
    endtask

    task automatic check_fvc(input fvc_t got, input fvc_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] hires_fvc got %h expected %h", got, exp));
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] fetch_addr got %h expected %h", got, exp));
        end
    endtask

    task automatic check_raster(input cycle_t got_cycle, input cycle_t exp_cyc,
                                input raster_t got_line, input raster_t exp_ln);
        if (got_cycle !== exp_cyc) begin
            stop_run($sformatf("[FAIL] cycle_num got %h expected %h", got_cycle, exp_cyc));
        end
        if (got_line !== exp_ln) begin
            stop_run($sformatf("[FAIL] raster_line got %h expected %h", got_line, exp_ln));
        end
    endtask

    // badline rule plus row, history and fast counter bookkeeping for one line
    task automatic model_line();
        if (exp_line == '0) begin
            den_latch = 1'b0;
            rows_seen = 0;
            fvc_lines = 0;
        end
        if (exp_line == first_dma_line) begin
            den_latch = den;
        end
        exp_badline = den_latch && exp_line >= first_dma_line &&
                      exp_line <= last_dma_line && exp_line[2:0] == yscroll;
        bl_hist = {bl_hist[6:0], exp_badline};
        if (exp_badline) begin
            rows_seen++;
            lines_since_bl = 0;
        end else begin
            lines_since_bl++;
        end
        // a line counts for the bitmap while any of the last 8 lines was a badline
        if (bl_hist != '0) begin
            fvc_lines++;
        end
    endtask

    // cycle 58 lies after every counter update of the line
    task automatic check_line();
        vc_t exp_vc;
        rc_t exp_rc;
        fvc_t exp_fvc;
        addr_t exp_addr;
        model_line();
        exp_vc = vc_t'(rows_seen * row_cells);
        // rc climbs one per line after a badline and then sticks at 7
        exp_rc = (rows_seen == 0 || lines_since_bl >= 7) ? rc_t'(7) : rc_t'(lines_since_bl + 1);
        exp_fvc = fvc_t'(fvc_lines * row_cells);
        check_bit("badline", badline, exp_badline);
        check_vc(hires_vc, exp_vc);
        check_rc(hires_rc, exp_rc);
        check_fvc(hires_fvc, exp_fvc);
        @(posedge clk_dot4x);
        #2;
        if (bitmap_mode) begin
            exp_addr = addr_t'(bitmap_base) * 16'd16384 + addr_t'(exp_fvc);
        end else begin
            exp_addr = addr_t'(matrix_base) * 16'd2048 + addr_t'(exp_vc);
        end
        check_addr(fetch_addr, exp_addr);
    endtask

    // one phi cycle, sampled just after phi rises when the cycle number is settled
    task automatic step_phi();
        @(posedge clk_phi);
        #2;
        check_raster(cycle_num, exp_cycle, raster_line, exp_line);
        if (exp_cycle == cycle_t'(58)) begin
            check_line();
        end
        if (exp_cycle == cycle_t'(cycles_per_line)) begin
            exp_cycle = cycle_t'(1);
            exp_line = (exp_line == raster_t'(lines_per_frame - 1)) ? '0 : exp_line + 1'b1;
        end else begin
            exp_cycle = exp_cycle + 1'b1;
        end
    endtask

    // inputs change in the last cycle of a frame, so a whole frame sees them
    task automatic run_frame(input logic den_val, input scroll_t y, input logic mode);
        den = den_val;
        yscroll = y;
        bitmap_mode = mode;
        matrix_base = 5'(3 * y + 1);
        bitmap_base = 2'(y);
        do begin
            step_phi();
        end while (!(exp_line == '0 && exp_cycle == cycle_t'(1)));
    endtask

    task automatic test_reset();
        check_vc(hires_vc, '0);
        check_rc(hires_rc, rc_t'(7));
        check_fvc(hires_fvc, '0);
        check_bit("badline", badline, 1'b0);
        check_bit("clk_phi", clk_phi, 1'b0);
        check_raster(cycle_num, cycle_t'(1), raster_line, '0);
    endtask

    // every yscroll value once, text and bitmap addressing take turns
    task automatic test_display_frames();
        for (int y = 0; y < 8; y++) begin
            run_frame(1'b1, scroll_t'(y), y[0]);
        end
    endtask

    task automatic test_den_off();
        run_frame(1'b0, scroll_t'(3), 1'b0);
    endtask

    initial begin
        rst = 1'b1;
        yscroll = '0;
        den = 1'b1;
        bitmap_mode = 1'b0;
        matrix_base = '0;
        bitmap_base = '0;
        // the first low-phase strobe after reset already steps past cycle 1
        exp_cycle = cycle_t'(2);
        exp_line = '0;
        den_latch = 1'b0;
        exp_badline = 1'b0;
        bl_hist = '0;
        rows_seen = 0;
        lines_since_bl = 0;
        fvc_lines = 0;
        repeat (3) @(posedge clk_dot4x);
        #2;
        rst = 1'b0;
        test_reset();
        test_display_frames();
        test_den_off();
        $display("No errors");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        stop_run("timeout: the tests did not finish within the expected number of frames");
    end

endmodule

/* vlog.f */
hw/video_pkg.sv
hw/raster_timing_if.sv
hw/phi_phase_gen.sv
hw/raster_counter.sv
hw/badline_detect.sv
hw/hires_matrix.sv
hw/hires_fetch_addr.sv
hw/hires_video_timing.sv
verification/tb_hires_video_timing.sv

/* Bender.yml */
package:
  name: hires_video_timing

sources:
  - hw/video_pkg.sv
  - hw/raster_timing_if.sv
  - hw/phi_phase_gen.sv
  - hw/raster_counter.sv
  - hw/badline_detect.sv
  - hw/hires_matrix.sv
  - hw/hires_fetch_addr.sv
  - hw/hires_video_timing.sv
  - target: test
    files:
      - verification/tb_hires_video_timing.sv
